/* build.f */
logic/ex_pkg.sv
logic/forward_unit.sv
logic/alu.sv
logic/divider.sv
logic/execute_stage.sv
test/tb_clock.sv
test/execute_tb.sv

/* Makefile */
# Verilator build of the execute stage testbench
VERILATOR ?= verilator
TOP       ?= execute_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, exit status is pass or fail"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* test/execute_tb.sv */
`timescale 1ns/1ps

module execute_tb;

    localparam int xlen = 32;

    logic                 clk;
    logic                 rst;
    ex_pkg::id_ex_ctrl_t  id_ex_ctrl;
    logic [xlen-1:0]      rs1_data;
    logic [xlen-1:0]      rs2_data;
    logic [xlen-1:0]      immediate;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      pc_plus4;
    ex_pkg::wb_fwd_t      wb_fwd;
    logic [xlen-1:0]      wb_data;
    logic                 ext_stall;
    ex_pkg::ex_mem_ctrl_t ex_mem_ctrl;
    logic [xlen-1:0]      ex_mem_result;
    logic [xlen-1:0]      ex_mem_store_data;
    logic [xlen-1:0]      ex_mem_pc_plus4;
    logic                 pc_redirect;
    logic [xlen-1:0]      redirect_addr;
    logic [xlen-1:0]      rs2_fwd_data;
    logic                 div_stall;

    integer               seed;
    // model copy of the ex/mem register, kept apart from the dut
    ex_pkg::reg_idx_t     m_rd;
    logic                 m_wr;
    logic [xlen-1:0]      m_result;

    tb_clock u_clk (
        .clk (clk)
    );

    execute_stage #(
        .xlen (xlen)
    ) u_dut (
        .clk               (clk),
        .rst               (rst),
        .id_ex_ctrl        (id_ex_ctrl),
        .rs1_data          (rs1_data),
        .rs2_data          (rs2_data),
        .immediate         (immediate),
        .pc                (pc),
        .pc_plus4          (pc_plus4),
        .wb_fwd            (wb_fwd),
        .wb_data           (wb_data),
        .ext_stall         (ext_stall),
        .ex_mem_ctrl       (ex_mem_ctrl),
        .ex_mem_result     (ex_mem_result),
        .ex_mem_store_data (ex_mem_store_data),
        .ex_mem_pc_plus4   (ex_mem_pc_plus4),
        .pc_redirect       (pc_redirect),
        .redirect_addr     (redirect_addr),
        .rs2_fwd_data      (rs2_fwd_data),
        .div_stall         (div_stall)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_ctrl(input ex_pkg::ex_mem_ctrl_t got, input ex_pkg::ex_mem_ctrl_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL ex_mem_ctrl got %h expected %h", got, exp));
        end
    endtask

    task automatic check_data(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    // uniform draw in 0..n-1
    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // ex/mem first, then write-back, x0 never forwarded
    function automatic logic [xlen-1:0] forwarded(input ex_pkg::reg_idx_t src,
                                                  input logic [xlen-1:0] reg_val);
        if (m_wr && (m_rd != '0) && (m_rd == src)) return m_result;
        if (wb_fwd.reg_wr_en && (wb_fwd.rd != '0) && (wb_fwd.rd == src)) return wb_data;
        return reg_val;
    endfunction

    function automatic logic expect_taken(input ex_pkg::id_ex_ctrl_t c,
                                          input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        if ((c.op == ex_pkg::OP_JAL) || (c.op == ex_pkg::OP_JALR)) return 1'b1;
        if (c.op != ex_pkg::OP_BRANCH) return 1'b0;
        case (c.funct3)
            ex_pkg::F3_BEQ:  return a == b;
            ex_pkg::F3_BNE:  return a != b;
            ex_pkg::F3_BLT:  return $signed(a) < $signed(b);
            ex_pkg::F3_BGE:  return $signed(a) >= $signed(b);
            ex_pkg::F3_BLTU: return a < b;
            ex_pkg::F3_BGEU: return a >= b;
            default:         return 1'b0;
        endcase
    endfunction

    function automatic logic [xlen-1:0] expect_result(input ex_pkg::id_ex_ctrl_t c,
                                                      input logic [xlen-1:0] a,
                                                      input logic [xlen-1:0] b);
        logic [2*xlen-1:0]      sa;
        logic [2*xlen-1:0]      sb;
        logic [2*xlen-1:0]      ua;
        logic [2*xlen-1:0]      ub;
        logic [2*xlen-1:0]      prod;
        logic signed [xlen-1:0] q_s;
        logic signed [xlen-1:0] r_s;
        logic signed [xlen-1:0] sra_v;
        logic                   ovf;
        // sign or zero extended to double width, low half of the product is exact
        sa    = {{xlen{a[xlen-1]}}, a};
        sb    = {{xlen{b[xlen-1]}}, b};
        ua    = {{xlen{1'b0}}, a};
        ub    = {{xlen{1'b0}}, b};
        ovf   = (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);
        sra_v = $signed(a) >>> b[4:0];
        q_s   = '0;
        r_s   = '0;
        if ((b != '0) && !ovf) begin
            q_s = $signed(a) / $signed(b);
            r_s = $signed(a) % $signed(b);
        end
        if (c.op == ex_pkg::OP_LUI) return b;
        if (c.op == ex_pkg::OP_JALR) return (a + b) & ~{{(xlen-1){1'b0}}, 1'b1};
        if ((c.op == ex_pkg::OP_R) && (c.funct7 == ex_pkg::FUNCT7_MULDIV)) begin
            case (c.funct3)
                ex_pkg::F3_MULH:   prod = sa * sb;
                ex_pkg::F3_MULHSU: prod = sa * ub;
                default:           prod = ua * ub;
            endcase
            case (c.funct3)
                ex_pkg::F3_MUL:  return prod[xlen-1:0];
                ex_pkg::F3_DIV:  return (b == '0) ? '1 : (ovf ? a : q_s);
                ex_pkg::F3_DIVU: return (b == '0) ? '1 : a / b;
                ex_pkg::F3_REM:  return (b == '0) ? a : (ovf ? '0 : r_s);
                ex_pkg::F3_REMU: return (b == '0) ? a : a % b;
                default:         return prod[2*xlen-1:xlen];
            endcase
        end
        // auipc, loads, stores, jal and branches all land on the plain sum
        if ((c.op != ex_pkg::OP_R) && (c.op != ex_pkg::OP_I)) return a + b;
        case (c.funct3)
            ex_pkg::F3_ADD_SUB: begin
                if ((c.op == ex_pkg::OP_R) && (c.funct7 == ex_pkg::FUNCT7_ALT)) return a - b;
                return a + b;
            end
            ex_pkg::F3_SLL:     return a << b[4:0];
            ex_pkg::F3_SLT:     return xlen'($signed(a) < $signed(b));
            ex_pkg::F3_SLTU:    return xlen'(a < b);
            ex_pkg::F3_XOR:     return a ^ b;
            ex_pkg::F3_SRL_SRA: begin
                if (c.funct7 == ex_pkg::FUNCT7_ALT) return sra_v;
                return a >> b[4:0];
            end
            ex_pkg::F3_OR:      return a | b;
            default:            return a & b;
        endcase
    endfunction

    // random instruction on the dut inputs, registers 0..3 so hazards are common
    task automatic make_instr();
        ex_pkg::id_ex_ctrl_t c;
        logic [xlen-1:0]     r;
        int                  kind;
        int                  sub;
        r           = $random(seed);
        kind        = pick(12);
        c           = '0;
        c.rs1       = 5'(pick(4));
        c.rs2       = (pick(4) == 0) ? c.rs1 : 5'(pick(4));
        c.rd        = 5'(pick(4));
        c.halt      = (pick(16) == 0);
        c.reg_wr_en = 1'b1;
        rs1_data    = $random(seed);
        rs2_data    = $random(seed);
        immediate   = {{(xlen-12){r[11]}}, r[11:0]};
        pc          = {r[xlen-1:2], 2'b00} ^ 32'h0001_0000;
        case (kind)
            0: begin
                c.op     = ex_pkg::OP_R;
                c.funct3 = 3'(pick(8));
                if (((c.funct3 == ex_pkg::F3_ADD_SUB) || (c.funct3 == ex_pkg::F3_SRL_SRA))
                    && (pick(2) == 1)) begin
                    c.funct7 = ex_pkg::FUNCT7_ALT;
                end
            end
            1: begin
                c.op          = ex_pkg::OP_I;
                c.imm_rs2_sel = 1'b1;
                c.funct3      = 3'(pick(8));
                if ((c.funct3 == ex_pkg::F3_SRL_SRA) && (pick(2) == 1)) begin
                    c.funct7 = ex_pkg::FUNCT7_ALT;
                end
            end
            2, 3: begin
                c.op          = (kind == 2) ? ex_pkg::OP_LUI : ex_pkg::OP_AUIPC;
                c.pc_rs1_sel  = (kind == 3);
                c.imm_rs2_sel = 1'b1;
                immediate     = {r[xlen-1:12], 12'b0};
            end
            4: begin
                c.op          = ex_pkg::OP_LOAD;
                c.imm_rs2_sel = 1'b1;
                c.wb_sel      = 2'b01;
            end
            5: begin
                c.op          = ex_pkg::OP_STORE;
                c.imm_rs2_sel = 1'b1;
                c.mem_wr_en   = 1'b1;
                c.reg_wr_en   = 1'b0;
            end
            6: begin
                c.op     = ex_pkg::OP_R;
                c.funct7 = ex_pkg::FUNCT7_MULDIV;
                c.funct3 = 3'(pick(4));
            end
            7, 8: begin
                // six branch kinds sit at funct3 0, 1 and 4..7
                sub               = pick(6);
                c.op              = ex_pkg::OP_BRANCH;
                c.funct3          = 3'((sub < 2) ? sub : sub + 2);
                c.jump_branch_sel = 1'b1;
                c.reg_wr_en       = 1'b0;
                immediate[0]      = 1'b0;
            end
            9: begin
                c.op              = ex_pkg::OP_JAL;
                c.pc_rs1_sel      = 1'b1;
                c.imm_rs2_sel     = 1'b1;
                c.jump_branch_sel = 1'b1;
                c.wb_sel          = 2'b10;
            end
            10: begin
                c.op          = ex_pkg::OP_JALR;
                c.imm_rs2_sel = 1'b1;
                c.wb_sel      = 2'b10;
            end
            default: begin
                c.op     = ex_pkg::OP_R;
                c.funct7 = ex_pkg::FUNCT7_MULDIV;
                c.funct3 = 3'(4 + pick(4));
                // x8 and x9 never see a write here, so these operands are exact
                sub = pick(4);
                if (sub < 2) begin
                    c.rs1    = 5'd8;
                    c.rs2    = 5'd9;
                    rs2_data = (sub == 0) ? '0 : '1;
                    if (sub == 1) begin
                        rs1_data = {1'b1, {(xlen-1){1'b0}}};
                    end
                end
            end
        endcase
        id_ex_ctrl       = c;
        pc_plus4         = pc + 4;
        wb_fwd.reg_wr_en = (pick(2) == 1);
        wb_fwd.rd        = 5'(pick(4));
        wb_data          = $random(seed);
        // no back-pressure on a divide, it would stay in flight
        ext_stall        = (kind < 11) && (pick(10) == 0);
    endtask

    // one instruction from issue to its ex/mem result
    task automatic run_one();
        ex_pkg::id_ex_ctrl_t  c;
        ex_pkg::ex_mem_ctrl_t exp_ctrl;
        logic [xlen-1:0]      a;
        logic [xlen-1:0]      b;
        logic [xlen-1:0]      rs2v;
        logic [xlen-1:0]      exp_res;
        logic                 is_div;
        logic                 long_div;
        logic                 jumpy;
        int                   waited;
        make_instr();
        c        = id_ex_ctrl;
        rs2v     = forwarded(c.rs2, rs2_data);
        a        = c.pc_rs1_sel ? pc : forwarded(c.rs1, rs1_data);
        b        = c.imm_rs2_sel ? immediate : rs2v;
        exp_res  = expect_result(c, a, b);
        is_div   = (c.op == ex_pkg::OP_R) && (c.funct7 == ex_pkg::FUNCT7_MULDIV) && c.funct3[2];
        // zero divisor and signed overflow finish without stalling
        long_div = is_div && (b != '0)
                   && !((c.funct3[0] == 1'b0) && (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1));
        jumpy    = (c.op == ex_pkg::OP_BRANCH) || (c.op == ex_pkg::OP_JAL)
                   || (c.op == ex_pkg::OP_JALR);
        #5;
        check_data("rs2_fwd_data", rs2_fwd_data, rs2v);
        check_bit("pc_redirect", pc_redirect, expect_taken(c, a, b));
        check_bit("div_stall", div_stall, long_div);
        if (jumpy) begin
            // jalr goes to its own sum, branches and jal to pc plus offset
            check_data("redirect_addr", redirect_addr,
                       (c.op == ex_pkg::OP_JALR) ? exp_res : pc + immediate);
        end
        @(posedge clk);
        #1;
        if (long_div) begin
            waited = 0;
            while (div_stall) begin
                check_ctrl(ex_mem_ctrl, '0);
                waited++;
                if (waited > 100) begin
                    abort_run("divider never finished, div_stall still high after 100 cycles");
                end
                @(posedge clk);
                #1;
            end
            // result cycle: the register still holds the last bubble
            check_ctrl(ex_mem_ctrl, '0);
            // with a bubble in ex/mem, rs2 comes from write-back or the register
            m_wr = 1'b0;
            rs2v = forwarded(c.rs2, rs2_data);
            @(posedge clk);
            #1;
        end
        if (ext_stall) begin
            exp_ctrl = '0;
        end else begin
            exp_ctrl = '{funct3: c.funct3, mem_wr_en: c.mem_wr_en, reg_wr_en: c.reg_wr_en,
                         wb_sel: c.wb_sel, rd: c.rd, halt: c.halt};
        end
        check_ctrl(ex_mem_ctrl, exp_ctrl);
        if (ext_stall) begin
            check_data("ex_mem_result", ex_mem_result, '0);
            check_data("ex_mem_store_data", ex_mem_store_data, '0);
            check_data("ex_mem_pc_plus4", ex_mem_pc_plus4, '0);
        end else begin
            // branch result carries no meaning downstream
            if (c.op != ex_pkg::OP_BRANCH) begin
                check_data("ex_mem_result", ex_mem_result, exp_res);
            end
            check_data("ex_mem_store_data", ex_mem_store_data, rs2v);
            check_data("ex_mem_pc_plus4", ex_mem_pc_plus4, pc_plus4);
        end
        m_rd     = exp_ctrl.rd;
        m_wr     = exp_ctrl.reg_wr_en;
        m_result = ext_stall ? '0 : exp_res;
    endtask

    initial begin
        seed       = 32629;
        rst        = 1'b1;
        id_ex_ctrl = '0;
        rs1_data   = '0;
        rs2_data   = '0;
        immediate  = '0;
        pc         = '0;
        pc_plus4   = '0;
        wb_fwd     = '0;
        wb_data    = '0;
        ext_stall  = 1'b0;
        m_rd       = '0;
        m_wr       = 1'b0;
        m_result   = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        // reset leaves a bubble and an idle divider
        check_ctrl(ex_mem_ctrl, '0);
        check_bit("div_stall", div_stall, 1'b0);
        for (int i = 0; i < 600; i++) begin
            run_one();
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period_ns = 4
) (
    output logic clk
);

    // free running, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(half_period_ns) clk = ~clk;
        end
    end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage #(
    parameter int xlen = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  ex_pkg::id_ex_ctrl_t  id_ex_ctrl,
    input  logic [xlen-1:0]      rs1_data,
    input  logic [xlen-1:0]      rs2_data,
    input  logic [xlen-1:0]      immediate,
    input  logic [xlen-1:0]      pc,
    input  logic [xlen-1:0]      pc_plus4,
    input  ex_pkg::wb_fwd_t      wb_fwd,
    input  logic [xlen-1:0]      wb_data,
    input  logic                 ext_stall,
    output ex_pkg::ex_mem_ctrl_t ex_mem_ctrl,
    output logic [xlen-1:0]      ex_mem_result,
    output logic [xlen-1:0]      ex_mem_store_data,
    output logic [xlen-1:0]      ex_mem_pc_plus4,
    output logic                 pc_redirect,
    output logic [xlen-1:0]      redirect_addr,
    output logic [xlen-1:0]      rs2_fwd_data,
    output logic                 div_stall
);

    ex_pkg::fwd_sel_t rs1_sel;
    ex_pkg::fwd_sel_t rs2_sel;
    logic [xlen-1:0]  rs1_fwd;
    logic [xlen-1:0]  in1;
    logic [xlen-1:0]  in2;
    logic [xlen-1:0]  alu_result;
    logic             branch_taken;
    logic             div_op;
    logic             div_signed;
    logic             div_rem;
    logic [xlen-1:0]  quotient;
    logic [xlen-1:0]  remainder;
    logic             div_busy;
    logic             div_done;
    logic [xlen-1:0]  ex_result;
    logic [xlen-1:0]  branch_target;

    forward_unit u_fwd (
        .rs1              (id_ex_ctrl.rs1),
        .rs2              (id_ex_ctrl.rs2),
        .ex_mem_rd        (ex_mem_ctrl.rd),
        .ex_mem_reg_wr_en (ex_mem_ctrl.reg_wr_en),
        .wb_fwd           (wb_fwd),
        .rs1_sel          (rs1_sel),
        .rs2_sel          (rs2_sel)
    );

    // forwarded register values
    always_comb begin
        case (rs1_sel)
            ex_pkg::FWD_EXMEM: rs1_fwd = ex_mem_result;
            ex_pkg::FWD_WB:    rs1_fwd = wb_data;
            default:           rs1_fwd = rs1_data;
        endcase
        // rs2 ignores the immediate select, it is also the store data
        case (rs2_sel)
            ex_pkg::FWD_EXMEM: rs2_fwd_data = ex_mem_result;
            ex_pkg::FWD_WB:    rs2_fwd_data = wb_data;
            default:           rs2_fwd_data = rs2_data;
        endcase
    end

    // pc and immediate win over any forwarded register
    assign in1 = id_ex_ctrl.pc_rs1_sel ? pc : rs1_fwd;
    assign in2 = id_ex_ctrl.imm_rs2_sel ? immediate : rs2_fwd_data;

    alu #(
        .xlen (xlen)
    ) u_alu (
        .in1          (in1),
        .in2          (in2),
        .op           (id_ex_ctrl.op),
        .funct3       (id_ex_ctrl.funct3),
        .funct7       (id_ex_ctrl.funct7),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    // div, divu, rem, remu all sit in the upper half of the muldiv funct3 space
    assign div_op     = (id_ex_ctrl.op == ex_pkg::OP_R)
                        && (id_ex_ctrl.funct7 == ex_pkg::FUNCT7_MULDIV)
                        && id_ex_ctrl.funct3[2];
    assign div_signed = (id_ex_ctrl.funct3 == ex_pkg::F3_DIV)
                        || (id_ex_ctrl.funct3 == ex_pkg::F3_REM);
    assign div_rem    = (id_ex_ctrl.funct3 == ex_pkg::F3_REM)
                        || (id_ex_ctrl.funct3 == ex_pkg::F3_REMU);

    divider #(
        .xlen (xlen)
    ) u_div (
        .clk        (clk),
        .rst        (rst),
        .start      (div_op),
        .signed_div (div_signed),
        .dividend   (in1),
        .divisor    (in2),
        .quotient   (quotient),
        .remainder  (remainder),
        .busy       (div_busy),
        .done       (div_done)
    );

    // stall from the first divide cycle until the result shows up
    assign div_stall = div_busy | (div_op & ~div_done);

    assign ex_result = div_op ? (div_rem ? remainder : quotient) : alu_result;

    // branch/jal target, jalr falls back to the execute result
    assign branch_target = pc + immediate;
    assign redirect_addr = id_ex_ctrl.jump_branch_sel ? branch_target : ex_result;
    assign pc_redirect   = branch_taken;

    // ex/mem register, any stall or reset loads a bubble
    always_ff @(posedge clk) begin
        if (rst || ext_stall || div_stall) begin
            ex_mem_ctrl       <= '0;
            ex_mem_result     <= '0;
            ex_mem_store_data <= '0;
            ex_mem_pc_plus4   <= '0;
        end else begin
            ex_mem_ctrl <= '{
                funct3:    id_ex_ctrl.funct3,
                mem_wr_en: id_ex_ctrl.mem_wr_en,
                reg_wr_en: id_ex_ctrl.reg_wr_en,
                wb_sel:    id_ex_ctrl.wb_sel,
                rd:        id_ex_ctrl.rd,
                halt:      id_ex_ctrl.halt
            };
            ex_mem_result     <= ex_result;
            ex_mem_store_data <= rs2_fwd_data;
            ex_mem_pc_plus4   <= pc_plus4;
        end
    end

endmodule

/* logic/divider.sv */
`timescale 1ns/1ps

module divider #(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic            signed_div,
    input  logic [xlen-1:0] dividend,
    input  logic [xlen-1:0] divisor,
    output logic [xlen-1:0] quotient,
    output logic [xlen-1:0] remainder,
    output logic            busy,
    output logic            done
);

    localparam int cnt_w = $clog2(xlen);

    ex_pkg::div_state_t state;
    logic [cnt_w-1:0]   count;
    logic [xlen-1:0]    rem_acc;
    logic [xlen-1:0]    quo_acc;
    logic [xlen-1:0]    div_mag;
    logic               neg_q;
    logic               neg_r;

    logic               a_neg;
    logic               b_neg;
    logic [xlen-1:0]    a_mag;
    logic [xlen-1:0]    b_mag;
    logic               div_zero;
    logic               overflow;
    logic               special;
    logic [xlen:0]      shifted;
    logic [xlen:0]      diff;
    logic               fits;

    // work on magnitudes, signs are put back at the end
    assign a_neg = signed_div & dividend[xlen-1];
    assign b_neg = signed_div & divisor[xlen-1];
    assign a_mag = a_neg ? -dividend : dividend;
    assign b_mag = b_neg ? -divisor : divisor;

    // cases that finish without iterating
    assign div_zero = (divisor == '0);
    assign overflow = signed_div && (dividend == {1'b1, {(xlen-1){1'b0}}}) && (divisor == '1);
    assign special  = div_zero | overflow;

    // one restoring step: bring in the next dividend bit and try the subtract
    assign shifted = {rem_acc, quo_acc[xlen-1]};
    assign diff    = shifted - {1'b0, div_mag};
    assign fits    = (shifted >= {1'b0, div_mag});

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ex_pkg::DIV_IDLE;
            count <= '0;
        end else begin
            case (state)
                ex_pkg::DIV_IDLE: begin
                    if (start && !special) begin
                        state <= ex_pkg::DIV_BUSY;
                        count <= cnt_w'(xlen - 1);
                    end
                end
                ex_pkg::DIV_BUSY: begin
                    if (count == '0) begin
                        state <= ex_pkg::DIV_DONE;
                    end
                    count <= count - cnt_w'(1);
                end
                // result is held for one cycle only
                ex_pkg::DIV_DONE: state <= ex_pkg::DIV_IDLE;
                default:          state <= ex_pkg::DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ex_pkg::DIV_IDLE) begin
            // quotient register starts out holding the dividend bits
            rem_acc <= '0;
            quo_acc <= a_mag;
            div_mag <= b_mag;
            neg_q   <= a_neg ^ b_neg;
            neg_r   <= a_neg;
        end else if (state == ex_pkg::DIV_BUSY) begin
            quo_acc <= {quo_acc[xlen-2:0], fits};
            rem_acc <= fits ? diff[xlen-1:0] : shifted[xlen-1:0];
        end
    end

    always_comb begin
        if ((state == ex_pkg::DIV_IDLE) && div_zero) begin
            quotient  = '1;
            remainder = dividend;
        end else if ((state == ex_pkg::DIV_IDLE) && overflow) begin
            quotient  = dividend;
            remainder = '0;
        end else begin
            // remainder takes the sign of the dividend
            quotient  = neg_q ? -quo_acc : quo_acc;
            remainder = neg_r ? -rem_acc : rem_acc;
        end
    end

    assign busy = (state == ex_pkg::DIV_BUSY);
    assign done = (state == ex_pkg::DIV_DONE) || ((state == ex_pkg::DIV_IDLE) && start && special);

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu #(
    parameter int xlen = 32
) (
    input  logic [xlen-1:0] in1,
    input  logic [xlen-1:0] in2,
    input  ex_pkg::opcode_t op,
    input  ex_pkg::funct3_t funct3,
    input  ex_pkg::funct7_t funct7,
    output logic [xlen-1:0] result,
    output logic            branch_taken
);

    localparam int shamt_w = $clog2(xlen);

    logic                     alt;
    logic [shamt_w-1:0]       shamt;
    logic [xlen-1:0]          sum;
    logic [xlen-1:0]          sra;
    logic [xlen-1:0]          base;
    logic                     eq;
    logic                     lt;
    logic                     ltu;
    logic signed [xlen:0]     m1;
    logic signed [xlen:0]     m2;
    logic signed [2*xlen+1:0] prod;

    assign alt   = (funct7 == ex_pkg::FUNCT7_ALT);
    assign shamt = in2[shamt_w-1:0];
    assign sum   = in1 + in2;
    assign eq    = (in1 == in2);
    assign lt    = ($signed(in1) < $signed(in2));
    assign ltu   = (in1 < in2);

    // arithmetic right shift, sign fills in from the top
    assign sra   = $signed(in1) >>> shamt;

    // one multiplier for the whole mul family
    // operands get an extra bit, sign or zero as the op asks
    assign m1   = {((funct3 == ex_pkg::F3_MULH) || (funct3 == ex_pkg::F3_MULHSU))
                   & in1[xlen-1], in1};
    assign m2   = {(funct3 == ex_pkg::F3_MULH) & in2[xlen-1], in2};
    assign prod = (2*xlen+2)'(m1) * (2*xlen+2)'(m2);

    // base integer ops, shared by register and immediate forms
    always_comb begin
        case (funct3)
            // immediate form never subtracts
            ex_pkg::F3_ADD_SUB: base = ((op == ex_pkg::OP_R) && alt) ? in1 - in2 : sum;
            ex_pkg::F3_SLL:     base = in1 << shamt;
            ex_pkg::F3_SLT:     base = {{(xlen-1){1'b0}}, lt};
            ex_pkg::F3_SLTU:    base = {{(xlen-1){1'b0}}, ltu};
            ex_pkg::F3_XOR:     base = in1 ^ in2;
            ex_pkg::F3_SRL_SRA: base = alt ? sra : in1 >> shamt;
            ex_pkg::F3_OR:      base = in1 | in2;
            ex_pkg::F3_AND:     base = in1 & in2;
            default:            base = sum;
        endcase
    end

    always_comb begin
        result       = sum;
        branch_taken = 1'b0;
        case (op)
            ex_pkg::OP_R: begin
                if (funct7 == ex_pkg::FUNCT7_MULDIV) begin
                    // divides come from the divider, leave zero here
                    if (funct3[2]) begin
                        result = '0;
                    end else if (funct3 == ex_pkg::F3_MUL) begin
                        result = prod[xlen-1:0];
                    end else begin
                        result = prod[2*xlen-1:xlen];
                    end
                end else begin
                    result = base;
                end
            end
            ex_pkg::OP_I:   result = base;
            ex_pkg::OP_LUI: result = in2;
            ex_pkg::OP_BRANCH: begin
                case (funct3)
                    ex_pkg::F3_BEQ:  branch_taken = eq;
                    ex_pkg::F3_BNE:  branch_taken = !eq;
                    ex_pkg::F3_BLT:  branch_taken = lt;
                    ex_pkg::F3_BGE:  branch_taken = !lt;
                    ex_pkg::F3_BLTU: branch_taken = ltu;
                    ex_pkg::F3_BGEU: branch_taken = !ltu;
                    default:         branch_taken = 1'b0;
                endcase
            end
            ex_pkg::OP_JAL: branch_taken = 1'b1;
            ex_pkg::OP_JALR: begin
                // jalr target has bit 0 forced low
                result       = {sum[xlen-1:1], 1'b0};
                branch_taken = 1'b1;
            end
            // address and auipc sums
            default: result = sum;
        endcase
    end

endmodule

/* logic/forward_unit.sv */
`timescale 1ns/1ps

module forward_unit (
    input  ex_pkg::reg_idx_t rs1,
    input  ex_pkg::reg_idx_t rs2,
    input  ex_pkg::reg_idx_t ex_mem_rd,
    input  logic             ex_mem_reg_wr_en,
    input  ex_pkg::wb_fwd_t  wb_fwd,
    output ex_pkg::fwd_sel_t rs1_sel,
    output ex_pkg::fwd_sel_t rs2_sel
);

    // a producer only counts when it writes something other than x0
    logic ex_mem_live;
    logic wb_live;

    assign ex_mem_live = ex_mem_reg_wr_en && (ex_mem_rd != '0);
    assign wb_live     = wb_fwd.reg_wr_en && (wb_fwd.rd != '0);

    // newest value wins: ex/mem ahead of write-back
    function automatic ex_pkg::fwd_sel_t pick(input ex_pkg::reg_idx_t src);
        ex_pkg::fwd_sel_t sel;
        sel = ex_pkg::FWD_REG;
        if (ex_mem_live && (ex_mem_rd == src)) begin
            sel = ex_pkg::FWD_EXMEM;
        end else if (wb_live && (wb_fwd.rd == src)) begin
            sel = ex_pkg::FWD_WB;
        end
        return sel;
    endfunction

    assign rs1_sel = pick(rs1);
    assign rs2_sel = pick(rs2);

endmodule

/* logic/ex_pkg.sv */
package ex_pkg;

    // field widths with a meaning of their own
    typedef logic [4:0] reg_idx_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    // 00 alu result, 01 memory load, 10 pc+4
    typedef logic [1:0] wb_sel_t;
    typedef logic [1:0] fwd_sel_t;

    // operand source selects
    localparam fwd_sel_t FWD_REG   = 2'b00;
    localparam fwd_sel_t FWD_WB    = 2'b01;
    localparam fwd_sel_t FWD_EXMEM = 2'b10;

    // major opcodes
    localparam opcode_t OP_R      = 7'b0110011;
    localparam opcode_t OP_I      = 7'b0010011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;

    // alu funct3
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // branch funct3
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // multiply/divide funct3
    localparam funct3_t F3_MUL    = 3'b000;
    localparam funct3_t F3_MULH   = 3'b001;
    localparam funct3_t F3_MULHSU = 3'b010;
    localparam funct3_t F3_MULHU  = 3'b011;
    localparam funct3_t F3_DIV    = 3'b100;
    localparam funct3_t F3_DIVU   = 3'b101;
    localparam funct3_t F3_REM    = 3'b110;
    localparam funct3_t F3_REMU   = 3'b111;

    localparam funct7_t FUNCT7_ALT    = 7'b0100000;
    localparam funct7_t FUNCT7_MULDIV = 7'b0000001;

    // decoded control out of id/ex, 40 bits
    typedef struct packed {
        opcode_t  op;
        funct3_t  funct3;
        funct7_t  funct7;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     pc_rs1_sel;
        logic     imm_rs2_sel;
        logic     jump_branch_sel;
        logic     mem_wr_en;
        logic     reg_wr_en;
        wb_sel_t  wb_sel;
        logic     halt;
    } id_ex_ctrl_t;

    // control carried on into mem
    typedef struct packed {
        funct3_t  funct3;
        logic     mem_wr_en;
        logic     reg_wr_en;
        wb_sel_t  wb_sel;
        reg_idx_t rd;
        logic     halt;
    } ex_mem_ctrl_t;

    // write-back bypass, data travels beside it
    typedef struct packed {
        logic     reg_wr_en;
        reg_idx_t rd;
    } wb_fwd_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_t;

endpackage
